/* common/battleship_pkg.sv */
package battleship_pkg;

    // ====================
    // grid and cell types
    // ====================
    localparam int GRID_SIZE = 9;

    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        SHIP  = 2'd1,
        MISS  = 2'd2,
        HIT   = 2'd3
    } cell_state_t;

    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } cell_addr_t;

    // cursor starts in the middle of the grid
    localparam cell_addr_t CURSOR_HOME = '{row: 4'd4, col: 4'd4};

    // ====================
    // player input
    // ====================
    typedef logic [9:0] joy_pos_t;

    // dead zone around the joystick centre
    localparam joy_pos_t JOY_LOW  = 10'd350;
    localparam joy_pos_t JOY_HIGH = 10'd650;

    // levels for the held directions, single-cycle pulses for the buttons
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic place;
        logic fire;
    } player_cmd_t;

    // ====================
    // screen geometry
    // ====================
    typedef logic [9:0] pixel_pos_t;

    localparam pixel_pos_t BOARD_X    = 10'd80;
    localparam pixel_pos_t BOARD_Y    = 10'd40;
    localparam pixel_pos_t CELL_SIZE  = 10'd40;
    localparam pixel_pos_t BORDER_W   = 10'd2;
    localparam pixel_pos_t BOARD_SPAN = 10'(GRID_SIZE * 40);

    // ====================
    // colours
    // ====================
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    localparam rgb_t COLOR_BLACK      = 12'h000;
    localparam rgb_t COLOR_BACKGROUND = 12'h004;
    localparam rgb_t COLOR_CURSOR     = 12'hCC0;
    // fill is the cell interior, edge is its border
    localparam rgb_t COLOR_EMPTY_FILL = 12'h006;
    localparam rgb_t COLOR_EMPTY_EDGE = 12'h888;
    localparam rgb_t COLOR_SHIP_FILL  = 12'h0A0;
    localparam rgb_t COLOR_SHIP_EDGE  = 12'h666;
    localparam rgb_t COLOR_MISS_FILL  = 12'hCCC;
    localparam rgb_t COLOR_MISS_EDGE  = 12'h666;
    localparam rgb_t COLOR_HIT_FILL   = 12'hC00;
    localparam rgb_t COLOR_HIT_EDGE   = 12'hA33;

endpackage

/* src/player_input.sv */
`timescale 1ns/1ps

module player_input import battleship_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  joy_pos_t    joy_x,
    input  joy_pos_t    joy_y,
    input  logic        joy_btn_c,
    input  logic        joy_btn_z,
    input  logic        btnr,
    input  logic        confirm_switch,
    input  logic        view_switch,
    output player_cmd_t cmd,
    output logic        blackout
);

    logic dir_left;
    logic dir_right;
    logic dir_up;
    logic dir_down;
    logic prev_btn_c;
    logic prev_btn_z;
    logic prev_btnr;
    logic prev_confirm;
    logic confirm_rise;
    logic saved_view;

    // ====================
    // joystick directions
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            dir_left  <= 1'b0;
            dir_right <= 1'b0;
            dir_up    <= 1'b0;
            dir_down  <= 1'b0;
        end else begin
            dir_left  <= (joy_x < JOY_LOW);
            dir_right <= (joy_x > JOY_HIGH);
            // small y means the stick is pushed up
            dir_up    <= (joy_y < JOY_LOW);
            dir_down  <= (joy_y > JOY_HIGH);
        end
    end

    // ====================
    // button edges
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_btn_c   <= 1'b0;
            prev_btn_z   <= 1'b0;
            prev_btnr    <= 1'b0;
            prev_confirm <= 1'b0;
        end else begin
            prev_btn_c   <= joy_btn_c;
            prev_btn_z   <= joy_btn_z;
            prev_btnr    <= btnr;
            prev_confirm <= confirm_switch;
        end
    end

    assign confirm_rise = confirm_switch & ~prev_confirm;

    always_comb begin
        cmd.left  = dir_left;
        cmd.right = dir_right;
        cmd.up    = dir_up;
        cmd.down  = dir_down;
        // either the stick button or the board button places a ship
        cmd.place = (joy_btn_c & ~prev_btn_c) | (btnr & ~prev_btnr);
        cmd.fire  = joy_btn_z & ~prev_btn_z;
    end

    // ====================
    // turn handoff
    // ====================
    // screen stays dark until the next player flips the view switch
    always_ff @(posedge clk) begin
        if (reset) begin
            blackout   <= 1'b0;
            saved_view <= 1'b0;
        end else if (confirm_rise) begin
            blackout   <= 1'b1;
            saved_view <= view_switch;
        end else if (blackout && (view_switch != saved_view)) begin
            blackout <= 1'b0;
        end
    end

endmodule

/* src/cursor_ctrl.sv */
`timescale 1ns/1ps

module cursor_ctrl import battleship_pkg::*; #(
    parameter int MOVE_DIV_BITS = 24
) (
    input  logic        clk,
    input  logic        reset,
    input  player_cmd_t cmd,
    output cell_addr_t  cursor
);

    localparam logic [3:0] LAST_IDX = 4'(GRID_SIZE - 1);

    logic [MOVE_DIV_BITS-1:0] move_div;
    logic                     move_tick;

    // free-running divider, one tick per wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            move_div <= '0;
        end else begin
            move_div <= move_div + 1'b1;
        end
    end

    assign move_tick = (move_div == '0);

    // ====================
    // clamped cursor
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            cursor <= CURSOR_HOME;
        end else if (move_tick) begin
            if (cmd.left && (cursor.col > 4'd0)) begin
                cursor.col <= cursor.col - 4'd1;
            end
            if (cmd.right && (cursor.col < LAST_IDX)) begin
                cursor.col <= cursor.col + 4'd1;
            end
            if (cmd.up && (cursor.row > 4'd0)) begin
                cursor.row <= cursor.row - 4'd1;
            end
            if (cmd.down && (cursor.row < LAST_IDX)) begin
                cursor.row <= cursor.row + 4'd1;
            end
        end
    end

endmodule

/* board/board_store.sv */
`timescale 1ns/1ps

module board_store import battleship_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  player_cmd_t cmd,
    input  cell_addr_t  cursor,
    input  logic        view_switch,
    input  logic        fire_mode,
    input  cell_addr_t  view_addr,
    output cell_state_t view_state
);

    // board 0 belongs to player 1, board 1 to player 2
    cell_state_t grid [2][GRID_SIZE][GRID_SIZE];

    logic        wr_board;
    logic        wr_en;
    cell_state_t old_state;
    cell_state_t new_state;

    // ====================
    // write port
    // ====================
    always_comb begin
        // placing goes to the shown board, firing to the opponent
        wr_board  = fire_mode ? ~view_switch : view_switch;
        wr_en     = fire_mode ? cmd.fire : cmd.place;
        old_state = grid[wr_board][cursor.row][cursor.col];
        if (!fire_mode) begin
            new_state = SHIP;
        end else begin
            case (old_state)
                EMPTY:   new_state = MISS;
                SHIP:    new_state = HIT;
                // repeated shots leave the cell alone
                default: new_state = old_state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < GRID_SIZE; r++) begin
                    for (int c = 0; c < GRID_SIZE; c++) begin
                        grid[b][r][c] <= EMPTY;
                    end
                end
            end
        end else if (wr_en) begin
            grid[wr_board][cursor.row][cursor.col] <= new_state;
        end
    end

    // ====================
    // display read port
    // ====================
    always_comb begin
        if ((view_addr.row < 4'(GRID_SIZE)) && (view_addr.col < 4'(GRID_SIZE))) begin
            view_state = grid[view_switch][view_addr.row][view_addr.col];
        end else begin
            view_state = EMPTY;
        end
    end

endmodule

/* render/board_render.sv */
`timescale 1ns/1ps

module board_render import battleship_pkg::*; (
    input  pixel_pos_t  pixel_x,
    input  pixel_pos_t  pixel_y,
    input  logic        video_on,
    input  logic        blackout,
    input  cell_addr_t  cursor,
    output cell_addr_t  view_addr,
    input  cell_state_t view_state,
    output rgb_t        pixel_rgb
);

    logic       in_board;
    pixel_pos_t rel_x;
    pixel_pos_t rel_y;
    pixel_pos_t cell_x;
    pixel_pos_t cell_y;
    pixel_pos_t local_x;
    pixel_pos_t local_y;
    logic       on_border;
    logic       on_cursor;

    // ====================
    // pixel to cell
    // ====================
    assign in_board = (pixel_x >= BOARD_X) && (pixel_x < BOARD_X + BOARD_SPAN) &&
                      (pixel_y >= BOARD_Y) && (pixel_y < BOARD_Y + BOARD_SPAN);

    // offsets from the board corner, only meaningful inside the board
    assign rel_x  = in_board ? (pixel_x - BOARD_X) : '0;
    assign rel_y  = in_board ? (pixel_y - BOARD_Y) : '0;
    assign cell_x = rel_x / CELL_SIZE;
    assign cell_y = rel_y / CELL_SIZE;

    // position inside the cell
    assign local_x = rel_x - cell_x * CELL_SIZE;
    assign local_y = rel_y - cell_y * CELL_SIZE;

    assign on_border = (local_x < BORDER_W) || (local_x >= CELL_SIZE - BORDER_W) ||
                       (local_y < BORDER_W) || (local_y >= CELL_SIZE - BORDER_W);

    assign view_addr.row = cell_y[3:0];
    assign view_addr.col = cell_x[3:0];

    assign on_cursor = in_board && (view_addr == cursor);

    // ====================
    // colour select
    // ====================
    always_comb begin
        if (blackout) begin
            // handoff hides the whole screen
            pixel_rgb = COLOR_BLACK;
        end else if (!video_on) begin
            pixel_rgb = COLOR_BLACK;
        end else if (!in_board) begin
            pixel_rgb = COLOR_BACKGROUND;
        end else if (on_cursor) begin
            // cursor covers border and interior alike
            pixel_rgb = COLOR_CURSOR;
        end else begin
            case (view_state)
                SHIP:    pixel_rgb = on_border ? COLOR_SHIP_EDGE : COLOR_SHIP_FILL;
                MISS:    pixel_rgb = on_border ? COLOR_MISS_EDGE : COLOR_MISS_FILL;
                HIT:     pixel_rgb = on_border ? COLOR_HIT_EDGE : COLOR_HIT_FILL;
                default: pixel_rgb = on_border ? COLOR_EMPTY_EDGE : COLOR_EMPTY_FILL;
            endcase
        end
    end

endmodule

/* src/battleship_top.sv */
`timescale 1ns/1ps

module battleship_top import battleship_pkg::*; #(
    parameter int MOVE_DIV_BITS = 24
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       view_switch,
    input  logic       confirm_switch,
    input  logic       fire_mode,
    input  logic       btnr,
    input  joy_pos_t   joy_x,
    input  joy_pos_t   joy_y,
    input  logic       joy_btn_c,
    input  logic       joy_btn_z,
    input  logic       video_on,
    input  pixel_pos_t pixel_x,
    input  pixel_pos_t pixel_y,
    output rgb_t       pixel_rgb
);

    player_cmd_t cmd;
    logic        blackout;
    cell_addr_t  cursor;
    cell_addr_t  view_addr;
    cell_state_t view_state;

    // ====================
    // control path
    // ====================
    player_input player_input_inst (
        .clk            (clk),
        .reset          (reset),
        .joy_x          (joy_x),
        .joy_y          (joy_y),
        .joy_btn_c      (joy_btn_c),
        .joy_btn_z      (joy_btn_z),
        .btnr           (btnr),
        .confirm_switch (confirm_switch),
        .view_switch    (view_switch),
        .cmd            (cmd),
        .blackout       (blackout)
    );

    cursor_ctrl #(
        .MOVE_DIV_BITS (MOVE_DIV_BITS)
    ) cursor_ctrl_inst (
        .clk    (clk),
        .reset  (reset),
        .cmd    (cmd),
        .cursor (cursor)
    );

    // ====================
    // game state and display
    // ====================
    board_store board_store_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .cursor      (cursor),
        .view_switch (view_switch),
        .fire_mode   (fire_mode),
        .view_addr   (view_addr),
        .view_state  (view_state)
    );

    board_render board_render_inst (
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .video_on   (video_on),
        .blackout   (blackout),
        .cursor     (cursor),
        .view_addr  (view_addr),
        .view_state (view_state),
        .pixel_rgb  (pixel_rgb)
    );

endmodule

/* tests/battleship_chk.sv */
`timescale 1ns/1ps

module battleship_chk import battleship_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        blackout,
    input cell_addr_t  cursor,
    input player_cmd_t cmd,
    input rgb_t        pixel_rgb
);

    localparam logic [3:0] LAST_IDX = 4'(GRID_SIZE - 1);

    // ====================
    // display
    // ====================
    blackout_is_dark: assert property (
        @(posedge clk) disable iff (reset)
        blackout |-> (pixel_rgb == COLOR_BLACK)
    ) else $error("pixel_rgb is not black while blackout is set");

    // ====================
    // cursor and actions
    // ====================
    cursor_in_grid: assert property (
        @(posedge clk) disable iff (reset)
        (cursor.row <= LAST_IDX) && (cursor.col <= LAST_IDX)
    ) else $error("cursor left the grid");

    // a single button edge never both places and fires
    one_action_per_cycle: assert property (
        @(posedge clk) disable iff (reset)
        !(cmd.place && cmd.fire)
    ) else $error("place and fire pulses in the same cycle");

endmodule

/* tests/tb_battleship.sv */
`timescale 1ns/1ps

module tb_battleship import battleship_pkg::*; ();

    localparam int MOVE_DIV_BITS   = 4;
    localparam int STEP_CYCLES     = 1 << MOVE_DIV_BITS;
    localparam int CYCLES_PER_LINE = 160;
    localparam joy_pos_t JOY_CENTRE    = 10'd512;
    localparam joy_pos_t JOY_PUSH_LOW  = 10'd100;
    localparam joy_pos_t JOY_PUSH_HIGH = 10'd900;

    logic       clk;
    logic       reset;
    logic       view_switch;
    logic       confirm_switch;
    logic       fire_mode;
    logic       btnr;
    joy_pos_t   joy_x;
    joy_pos_t   joy_y;
    logic       joy_btn_c;
    logic       joy_btn_z;
    logic       video_on;
    pixel_pos_t pixel_x;
    pixel_pos_t pixel_y;
    rgb_t       pixel_rgb;

    // one entry per data line
    string       test_name [$];
    string       test_op   [$];
    string       test_sel  [$];
    int          arg_a     [$];
    int          arg_b     [$];
    int          arg_c     [$];
    logic [11:0] exp_rgb   [$];

    int pass_count  = 0;
    int fail_count  = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    battleship_top #(
        .MOVE_DIV_BITS (MOVE_DIV_BITS)
    ) battleship_top_inst (
        .clk            (clk),
        .reset          (reset),
        .view_switch    (view_switch),
        .confirm_switch (confirm_switch),
        .fire_mode      (fire_mode),
        .btnr           (btnr),
        .joy_x          (joy_x),
        .joy_y          (joy_y),
        .joy_btn_c      (joy_btn_c),
        .joy_btn_z      (joy_btn_z),
        .video_on       (video_on),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .pixel_rgb      (pixel_rgb)
    );

    bind battleship_top battleship_chk battleship_chk_inst (
        .clk       (clk),
        .reset     (reset),
        .blackout  (blackout),
        .cursor    (cursor),
        .cmd       (cmd),
        .pixel_rgb (pixel_rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic note_failure(input string name, input string what);
        $display("test %s: %s", name, what);
        error_count++;
    endtask

    task automatic check_value(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_tests(output bit ok);
        int               fd;
        int               code;
        int               want;
        string            name;
        string            op;
        string            sel;
        int               a;
        int               b;
        int               c;
        logic [11:0]      rgb;
        logic [8*160-1:0] rest;
        ok = 1'b0;
        fd = $fopen("tests/battleship_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", name) == 1) begin
                sel = "";
                a = 0;
                b = 0;
                c = 0;
                rgb = '0;
                if (name.substr(0, 0) == "#") begin
                    // rest of a comment line
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%s", op);
                    if (op == "probe") begin
                        code = code + $fscanf(fd, "%d %d %d %h", a, b, c, rgb);
                        want = 5;
                    end else if (op == "press") begin
                        code = code + $fscanf(fd, "%s", sel);
                        want = 2;
                    end else begin
                        code = code + $fscanf(fd, "%s %d", sel, a);
                        want = 3;
                    end
                    if (code != want) begin
                        $display("incomplete data line for test %s", name);
                        ok = 1'b0;
                    end
                    test_name.push_back(name);
                    test_op.push_back(op);
                    test_sel.push_back(sel);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_c.push_back(c);
                    exp_rgb.push_back(rgb);
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // operations
    // ====================
    task automatic hold_joystick(input string name, input string dir, input int steps);
        if (dir == "left") begin
            joy_x <= JOY_PUSH_LOW;
        end else if (dir == "right") begin
            joy_x <= JOY_PUSH_HIGH;
        end else if (dir == "up") begin
            joy_y <= JOY_PUSH_LOW;
        end else if (dir == "down") begin
            joy_y <= JOY_PUSH_HIGH;
        end else begin
            note_failure(name, {"unknown joystick direction ", dir});
        end
        // one divider period per step
        wait_cycles(steps * STEP_CYCLES);
        joy_x <= JOY_CENTRE;
        joy_y <= JOY_CENTRE;
        wait_cycles(2);
    endtask

    task automatic drive_button(input string sel, input logic level);
        if (sel == "c") begin
            joy_btn_c <= level;
        end else if (sel == "z") begin
            joy_btn_z <= level;
        end else if (sel == "btnr") begin
            btnr <= level;
        end else begin
            confirm_switch <= level;
        end
    endtask

    task automatic press_button(input string name, input string sel);
        if (sel == "c" || sel == "z" || sel == "btnr" || sel == "confirm") begin
            drive_button(sel, 1'b1);
            wait_cycles(2);
            drive_button(sel, 1'b0);
            wait_cycles(2);
        end else begin
            note_failure(name, {"unknown button ", sel});
        end
    endtask

    task automatic change_switch(input string name, input string sel, input int value);
        if (sel == "view") begin
            view_switch <= (value != 0);
        end else if (sel == "fire_mode") begin
            fire_mode <= (value != 0);
        end else begin
            note_failure(name, {"unknown switch ", sel});
        end
        wait_cycles(2);
    endtask

    task automatic probe_pixel(input string name, input int x, input int y, input int von,
                               input logic [11:0] expected);
        pixel_x  <= pixel_pos_t'(x);
        pixel_y  <= pixel_pos_t'(y);
        video_on <= (von != 0);
        @(posedge clk);
        // sample away from the clock edge
        @(negedge clk);
        check_value(name, expected, pixel_rgb);
        @(posedge clk);
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        errors_before = error_count;
        if (test_op[idx] == "move") begin
            hold_joystick(test_name[idx], test_sel[idx], arg_a[idx]);
        end else if (test_op[idx] == "press") begin
            press_button(test_name[idx], test_sel[idx]);
        end else if (test_op[idx] == "set") begin
            change_switch(test_name[idx], test_sel[idx], arg_a[idx]);
        end else if (test_op[idx] == "probe") begin
            probe_pixel(test_name[idx], arg_a[idx], arg_b[idx], arg_c[idx], exp_rgb[idx]);
        end else begin
            note_failure(test_name[idx], {"unknown operation ", test_op[idx]});
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s passed", test_name[idx]);
        end else begin
            fail_count++;
            $display("test %s failed", test_name[idx]);
        end
    endtask

    // ====================
    // watchdog
    // ====================
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ====================
    // main sequence
    // ====================
    initial begin : main_sequence
        bit loaded;
        reset          = 1'b1;
        view_switch    = 1'b0;
        confirm_switch = 1'b0;
        fire_mode      = 1'b0;
        btnr           = 1'b0;
        joy_x          = JOY_CENTRE;
        joy_y          = JOY_CENTRE;
        joy_btn_c      = 1'b0;
        joy_btn_z      = 1'b0;
        video_on       = 1'b0;
        pixel_x        = '0;
        pixel_y        = '0;
        load_tests(loaded);
        if (!loaded || test_name.size() == 0) begin
            $display("could not read the tests from tests/battleship_tests.txt");
            error_count++;
        end
        cycle_limit = test_name.size() * CYCLES_PER_LINE + 100;
        wait_cycles(5);
        reset <= 1'b0;
        for (int i = 0; i < test_name.size(); i++) begin
            run_test(i);
        end
        $display("tests run %0d, passed %0d, failed %0d", test_name.size(), pass_count,
                 fail_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tests/battleship_tests.txt */
# columns: test_name operation arguments
# move dir steps | press button | set switch value | probe pixel_x pixel_y video_on rgb_hex
reset_home         probe 260 220 1 CC0
reset_empty_fill   probe 100 60 1 006
reset_empty_edge   probe 80 60 1 888
reset_outside      probe 20 20 1 004
reset_video_off    probe 260 220 0 000
move_up_2          move up 2
move_left_3        move left 3
cursor_at_2_1      probe 140 140 1 CC0
home_left_behind   probe 260 220 1 006
move_left_clamp    move left 5
cursor_at_2_0      probe 100 140 1 CC0
cell_2_1_empty     probe 140 140 1 006
place_c            press c
move_right_2       move right 2
place_btnr         press btnr
move_down_2        move down 2
ship_c_fill        probe 100 140 1 0A0
ship_c_edge        probe 80 140 1 666
ship_btnr_fill     probe 180 140 1 0A0
ship_btnr_edge     probe 180 120 1 666
cursor_at_4_2      probe 180 220 1 CC0
view_board_2       set view 1
board_2_no_ship_c  probe 100 140 1 006
board_2_no_ship_r  probe 180 140 1 006
place_board_2      press c
fire_mode_on       set fire_mode 1
view_board_1       set view 0
fire_hit           press z
move_right_1       move right 1
fire_miss          press z
move_up_1          move up 1
view_targets       set view 1
hit_fill           probe 180 220 1 C00
hit_edge           probe 180 200 1 A33
miss_fill          probe 220 220 1 CCC
miss_edge          probe 220 200 1 666
view_back_1        set view 0
board_1_hit_cell   probe 180 220 1 006
board_1_miss_cell  probe 220 220 1 006
board_1_ship_kept  probe 100 140 1 0A0
handoff_confirm    press confirm
dark_board         probe 100 140 1 000
dark_outside       probe 20 20 1 000
confirm_again      press confirm
still_dark         probe 220 220 1 000
view_flip          set view 1
back_miss          probe 220 220 1 CCC
back_outside       probe 20 20 1 004

/* files.f */
common/battleship_pkg.sv
src/player_input.sv
src/cursor_ctrl.sv
board/board_store.sv
render/board_render.sv
src/battleship_top.sv
tests/battleship_chk.sv
tests/tb_battleship.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_battleship -f files.f \
    -Mdir obj_dir -o tb_battleship \
    && ./obj_dir/tb_battleship 2>&1 | tee sim.log \
    || exit 1

grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1
